// ==== sources.f ====
src/logger_pkg.sv
src/cmd_regs.sv
src/pps_filter.sv
src/msg_channel.sv
src/ts_store.sv
src/logger_arbiter.sv
src/sample_mux.sv
src/logger_top.sv
tests/logger_asserts.sv
tests/tb_logger.sv

// ==== tests/tb_logger.sv ====
//----------------------------------------------------------
// event logger testbench
// clock, reset, command and gpio drivers, directed tests
// for reset, pps, denoise, message and back-to-back samples
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_logger import logger_pkg::*; ();

    localparam int PPS_BIT     = 3;    // gpio bit used as pps input
    localparam int MSG_BIT     = 6;    // gpio bit used as message trigger
    localparam int WAIT_CYCLES = 100;  // longest wait for a sample

    logic                    xclk;
    logic                    config_rst;
    logic                    cmd_we;
    logic [ADDR_W-1:0]       cmd_addr;
    logic [31:0]             cmd_data;
    logic [GPIO_N-1:0]       ext_di;
    logic [TIME_W-1:0]       ts_local;
    logic [WORD_W-1:0]       data;
    logic                    data_stb;
    logic [SAMPLE_CNT_W-1:0] sample_count;

    integer            seed;
    int                errors;
    int                timeouts;
    logic [WORD_W-1:0] msg_words [DATA_WORDS];  // last message written

    initial begin
        xclk = 1'b0;
        forever #10 xclk = ~xclk;  // 20 ns period
    end

    logger_top UUT (
        .i_xclk         (xclk),
        .i_config_rst   (config_rst),
        .i_cmd_we       (cmd_we),
        .i_cmd_addr     (cmd_addr),
        .i_cmd_data     (cmd_data),
        .i_ext_di       (ext_di),
        .i_ts_local     (ts_local),
        .o_data         (data),
        .o_data_stb     (data_stb),
        .o_sample_count (sample_count)
    );

    // n rising edges, then the 2 ns drive offset
    task automatic step(input int n);
        repeat (n) @(posedge xclk);
        #2;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got_v,
                                   input logic [31:0] exp_v);
        errors++;
        $display("ERR %0d ns: %s, got %h, expected %h", $time, what, got_v, exp_v);
    endtask

    task automatic cmd_write(input int addr, input logic [31:0] d);
        cmd_we   = 1'b1;
        cmd_addr = ADDR_W'(addr);
        cmd_data = d;
        step(1);
        cmd_we   = 1'b0;  // single-cycle strobe
    endtask

    // config fields from bit 0 up: pps_sel, pps_inv, pps_en, msg_sel, msg_inv, msg_en
    function automatic logic [31:0] cfg_word(input int pps_sel, input bit pps_inv,
                                             input bit pps_en, input int msg_sel,
                                             input bit msg_inv, input bit msg_en);
        cfg_word       = '0;
        cfg_word[3:0]  = pps_sel[3:0];
        cfg_word[4]    = pps_inv;
        cfg_word[5]    = pps_en;
        cfg_word[9:6]  = msg_sel[3:0];
        cfg_word[10]   = msg_inv;
        cfg_word[11]   = msg_en;
    endfunction

    // no strobe may appear over n cycles
    task automatic expect_quiet(input int n);
        for (int i = 0; i < n; i++) begin
            step(1);
            if (data_stb) begin
                report_mismatch("unexpected output strobe", data_stb, 0);
                return;
            end
        end
    endtask

    // waits for a sample, collects its eight words and compares them
    task automatic expect_sample(input bit chn, input logic [TIME_W-1:0] t,
                                 input bit with_msg, input int max_wait);
        logic [WORD_W-1:0] got_w [SAMPLE_WORDS];
        logic [WORD_W-1:0] exp_w [SAMPLE_WORDS];
        int                n;
        exp_w[0] = t[15:0];          // time low half
        exp_w[1] = {chn, t[30:16]};  // channel number in the msb
        for (int i = 0; i < DATA_WORDS; i++) begin
            exp_w[TS_WORDS+i] = with_msg ? msg_words[i] : '0;  // pps sends zeros
        end
        n = 0;
        @(negedge xclk);
        while (!data_stb && n < max_wait) begin
            @(negedge xclk);
            n++;
        end
        if (!data_stb) begin
            timeouts++;
            $display("no sample from channel %0d within %0d cycles", chn, max_wait);
            return;
        end
        for (int w = 0; w < SAMPLE_WORDS; w++) begin
            if (w > 0) @(negedge xclk);
            if (!data_stb) begin
                report_mismatch($sformatf("strobe at sample word %0d", w), data_stb, 1);
                return;
            end
            got_w[w] = data;
        end
        for (int w = 0; w < SAMPLE_WORDS; w++) begin
            if (got_w[w] !== exp_w[w])
                report_mismatch($sformatf("chn %0d sample word %0d", chn, w), got_w[w], exp_w[w]);
        end
    endtask

    task automatic test_reset_state();
        for (int i = 0; i < 60; i++) begin
            ext_di = GPIO_N'($random(seed));  // gpio noise, channels still off
            step(1);
            if (data_stb) report_mismatch("strobe with channels disabled", data_stb, 0);
        end
        ext_di = '0;
        expect_quiet(30);
        if (sample_count !== 0) report_mismatch("sample count after reset", sample_count, 0);
    endtask

    task automatic test_pps_sample();
        logic [TIME_W-1:0]       t;
        logic [SAMPLE_CNT_W-1:0] cnt0;
        cnt0 = sample_count;
        cmd_write(ADDR_CONFIG, cfg_word(PPS_BIT, 0, 1, MSG_BIT, 0, 0));
        step(4);
        t                = $random(seed);
        ts_local         = t;
        ext_di[PPS_BIT]  = 1'b1;
        expect_sample(1'b0, t, 1'b0, WAIT_CYCLES);
        step(10);                             // pulse held about 40 cycles
        ext_di[PPS_BIT]  = 1'b0;
        ts_local         = $random(seed);
        expect_quiet(40);                     // falling edge makes no sample
        if (sample_count !== cnt0 + 1) report_mismatch("count after pps", sample_count, cnt0 + 1);
    endtask

    task automatic test_pps_denoise();
        logic [TIME_W-1:0]       t;
        logic [SAMPLE_CNT_W-1:0] cnt0;
        cnt0 = sample_count;
        ext_di[PPS_BIT] = 1'b1;               // short glitches
        step(6);
        ext_di[PPS_BIT] = 1'b0;
        step(4);
        ext_di[PPS_BIT] = 1'b1;
        step(12);
        ext_di[PPS_BIT] = 1'b0;
        expect_quiet(40);
        cmd_write(ADDR_CONFIG, cfg_word(PPS_BIT, 0, 0, MSG_BIT, 0, 0));
        ext_di[PPS_BIT] = 1'b1;               // idle high for inverted polarity
        step(4);
        cmd_write(ADDR_CONFIG, cfg_word(PPS_BIT, 1, 1, MSG_BIT, 0, 0));
        expect_quiet(6);
        t               = $random(seed);
        ts_local        = t;
        ext_di[PPS_BIT] = 1'b0;               // falling input is the pulse
        expect_sample(1'b0, t, 1'b0, WAIT_CYCLES);
        expect_quiet(30);
        if (sample_count !== cnt0 + 1) report_mismatch("count after denoise", sample_count, cnt0 + 1);
    endtask

    task automatic test_msg_sample();
        logic [TIME_W-1:0]       t1;
        logic [SAMPLE_CNT_W-1:0] cnt0;
        cnt0 = sample_count;
        cmd_write(ADDR_CONFIG, cfg_word(PPS_BIT, 0, 0, MSG_BIT, 0, 1));
        for (int i = 0; i < DATA_WORDS; i++) begin
            msg_words[i] = WORD_W'($random(seed));
            cmd_write(ADDR_MSG_BASE + i, {16'($random(seed)), msg_words[i]});  // upper half junk
        end
        step(4);
        t1              = $random(seed);
        ts_local        = t1;
        ext_di[MSG_BIT] = 1'b1;               // leading edge takes the time
        expect_quiet(10);
        ts_local        = $random(seed);
        step(2);
        ext_di[MSG_BIT] = 1'b0;               // trailing edge releases the sample
        expect_sample(1'b1, t1, 1'b1, WAIT_CYCLES);
        expect_quiet(20);
        if (sample_count !== cnt0 + 1) report_mismatch("count after msg", sample_count, cnt0 + 1);
    endtask

    task automatic test_back_to_back();
        logic [TIME_W-1:0]       t_msg;
        logic [TIME_W-1:0]       t_pps;
        logic [SAMPLE_CNT_W-1:0] cnt0;
        cnt0 = sample_count;
        cmd_write(ADDR_CONFIG, cfg_word(PPS_BIT, 0, 1, MSG_BIT, 0, 1));
        step(4);
        t_msg           = $random(seed);
        ts_local        = t_msg;
        ext_di[MSG_BIT] = 1'b1;
        step(8);
        t_pps           = $random(seed);
        ts_local        = t_pps;
        ext_di[PPS_BIT] = 1'b1;
        step(18);                             // both channels eligible in the same cycle
        ext_di[MSG_BIT] = 1'b0;
        expect_sample(1'b0, t_pps, 1'b0, WAIT_CYCLES);
        expect_sample(1'b1, t_msg, 1'b1, 0);  // must follow with no gap
        ext_di[PPS_BIT] = 1'b0;
        expect_quiet(40);
        if (sample_count !== cnt0 + 2) report_mismatch("count after pair", sample_count, cnt0 + 2);
    endtask

    initial begin
        seed       = 32'hbd58;
        errors     = 0;
        timeouts   = 0;
        config_rst = 1'b1;
        cmd_we     = 1'b0;
        cmd_addr   = '0;
        cmd_data   = '0;
        ext_di     = '0;
        ts_local   = '0;
        for (int i = 0; i < DATA_WORDS; i++) msg_words[i] = '0;
        step(4);
        config_rst = 1'b0;
        step(2);
        test_reset_state();
        test_pps_sample();
        test_pps_denoise();
        test_msg_sample();
        test_back_to_back();
        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/logger_asserts.sv ====
//----------------------------------------------------------
// output strobe framing checks, bound to logger_top
//----------------------------------------------------------
`timescale 1ns/1ps

module logger_asserts import logger_pkg::*; (
    input logic i_xclk,
    input logic i_config_rst,
    input logic i_data_stb
);

    logic [$clog2(SAMPLE_WORDS)-1:0] stb_cnt;  // strobes seen, modulo sample length

    always_ff @(posedge i_xclk) begin
        if (i_config_rst)    stb_cnt <= '0;
        else if (i_data_stb) stb_cnt <= stb_cnt + 1'b1;
    end

    stb_low_in_reset: assert property (@(posedge i_xclk) i_config_rst |=> !i_data_stb)
        else $error("output strobe high while in reset");

    // a sample is 8 strobes, back-to-back samples stay high longer
    stb_full_sample: assert property (@(posedge i_xclk) disable iff (i_config_rst)
        $rose(i_data_stb) |-> i_data_stb [*SAMPLE_WORDS])
        else $error("output strobe shorter than one sample");

    stb_ends_on_sample: assert property (@(posedge i_xclk) disable iff (i_config_rst)
        $fell(i_data_stb) |-> (stb_cnt == 0))
        else $error("output strobe ended inside a sample");

endmodule

bind logger_top logger_asserts u_logger_asserts (
    .i_xclk       (i_xclk),
    .i_config_rst (i_config_rst),
    .i_data_stb   (o_data_stb)
);

// ==== src/logger_top.sv ====
//----------------------------------------------------------
// event logger top level, xclk domain
// command regs, pps and msg channels, ts store, arbiter, mux
//----------------------------------------------------------
`timescale 1ns/1ps

module logger_top import logger_pkg::*; (
    input  logic                    i_xclk,
    input  logic                    i_config_rst,
    input  logic                    i_cmd_we,
    input  logic [ADDR_W-1:0]       i_cmd_addr,
    input  logic [31:0]             i_cmd_data,
    input  logic [GPIO_N-1:0]       i_ext_di,
    input  logic [TIME_W-1:0]       i_ts_local,
    output logic [WORD_W-1:0]       o_data,
    output logic                    o_data_stb,
    output logic [SAMPLE_CNT_W-1:0] o_sample_count
);

    logger_cfg_t        cfg;
    msg_wr_t            msg_wr;
    word_sel_t          sel;
    logic [NUM_CHN-1:0] ts_rq;     // 0 - pps, 1 - msg
    logic [NUM_CHN-1:0] rdy;
    logic [NUM_CHN-1:0] next;
    logic [NUM_CHN-1:0] done;
    logic [NUM_CHN-1:0] ts_valid;
    logic [WORD_W-1:0]  msg_data;
    logic [WORD_W-1:0]  ts_word;

    cmd_regs u_cmd_regs (
        .i_xclk       (i_xclk),
        .i_config_rst (i_config_rst),
        .i_cmd_we     (i_cmd_we),
        .i_cmd_addr   (i_cmd_addr),
        .i_cmd_data   (i_cmd_data),
        .o_cfg        (cfg),
        .o_msg_wr     (msg_wr)
    );

    pps_filter u_pps_filter (
        .i_xclk       (i_xclk),
        .i_config_rst (i_config_rst),
        .i_cfg        (cfg),
        .i_ext_di     (i_ext_di),
        .i_next       (next[0]),
        .o_ts_rq      (ts_rq[0]),
        .o_rdy        (rdy[0])
    );

    msg_channel u_msg_channel (
        .i_xclk       (i_xclk),
        .i_config_rst (i_config_rst),
        .i_cfg        (cfg),
        .i_msg_wr     (msg_wr),
        .i_ext_di     (i_ext_di),
        .i_next       (next[1]),
        .o_ts_rq      (ts_rq[1]),
        .o_rdy        (rdy[1]),
        .o_data       (msg_data)
    );

    ts_store u_ts_store (
        .i_xclk       (i_xclk),
        .i_config_rst (i_config_rst),
        .i_ts_rq      (ts_rq),
        .i_ts_local   (i_ts_local),
        .i_done       (done),
        .i_sel        (sel),
        .o_ts_valid   (ts_valid),
        .o_ts_word    (ts_word)
    );

    logger_arbiter u_logger_arbiter (
        .i_xclk         (i_xclk),
        .i_config_rst   (i_config_rst),
        .i_ts_valid     (ts_valid),
        .i_rdy          (rdy),
        .o_sel          (sel),
        .o_next         (next),
        .o_done         (done),
        .o_sample_count (o_sample_count)
    );

    sample_mux u_sample_mux (
        .i_xclk       (i_xclk),
        .i_config_rst (i_config_rst),
        .i_sel        (sel),
        .i_ts_word    (ts_word),
        .i_rdy        (rdy),
        .i_msg_data   (msg_data),
        .o_data       (o_data),
        .o_data_stb   (o_data_stb)
    );

endmodule

// ==== src/sample_mux.sv ====
//----------------------------------------------------------
// registered output multiplexer
// timestamp, channel data or zero fill, output strobe
//----------------------------------------------------------
`timescale 1ns/1ps

module sample_mux import logger_pkg::*; (
    input  logic               i_xclk,
    input  logic               i_config_rst,
    input  word_sel_t          i_sel,
    input  logic [WORD_W-1:0]  i_ts_word,
    input  logic [NUM_CHN-1:0] i_rdy,
    input  logic [WORD_W-1:0]  i_msg_data,
    output logic [WORD_W-1:0]  o_data,
    output logic               o_data_stb   // one cycle per word
);

    logic [WORD_W-1:0] chn_data [NUM_CHN];

    assign chn_data[0] = '0;          // pps has no payload
    assign chn_data[1] = i_msg_data;

    always_ff @(posedge i_xclk) begin
        if (i_config_rst) o_data_stb <= 1'b0;
        else              o_data_stb <= i_sel.valid;
    end

    always_ff @(posedge i_xclk) begin
        if (i_sel.ts_en)            o_data <= i_ts_word;
        else if (i_rdy[i_sel.chn])  o_data <= chn_data[i_sel.chn];
        else                        o_data <= '0;  // channel ran out of data
    end

endmodule

// ==== src/logger_arbiter.sv ====
//----------------------------------------------------------
// sample arbiter
// fixed-priority channel pick, eight-word sequencing,
// sample counter
//----------------------------------------------------------
`timescale 1ns/1ps

module logger_arbiter import logger_pkg::*; (
    input  logic                    i_xclk,
    input  logic                    i_config_rst,
    input  logic [NUM_CHN-1:0]      i_ts_valid,
    input  logic [NUM_CHN-1:0]      i_rdy,
    output word_sel_t               o_sel,
    output logic [NUM_CHN-1:0]      o_next,          // one per data word
    output logic [NUM_CHN-1:0]      o_done,          // last word of sample
    output logic [SAMPLE_CNT_W-1:0] o_sample_count
);

    logic                            busy;
    logic [$clog2(SAMPLE_WORDS)-1:0] word_cnt;
    logic [CHN_W-1:0]                chn;
    logic                            last_word;
    logic [NUM_CHN-1:0]              elig;      // valid and ready channels
    logic [CHN_W-1:0]                pick;

    assign last_word = busy && (word_cnt == SAMPLE_WORDS - 1);

    assign o_sel.valid  = busy;
    assign o_sel.ts_en  = busy && (word_cnt < TS_WORDS);
    assign o_sel.chn    = chn;
    assign o_sel.ts_idx = word_cnt[1:0];    // meaningful only with ts_en

    assign o_next = (busy && (word_cnt >= TS_WORDS)) ? (NUM_CHN'(1) << chn) : '0;
    assign o_done = last_word ? (NUM_CHN'(1) << chn) : '0;

    // channel just finished still shows valid this cycle
    assign elig = i_ts_valid & i_rdy & ~o_done;

    always_comb begin
        pick = '0;
        for (int c = NUM_CHN - 1; c >= 0; c--) begin
            if (elig[c]) pick = CHN_W'(c);  // lowest number wins
        end
    end

    always_ff @(posedge i_xclk) begin
        if (i_config_rst) begin
            busy           <= 1'b0;
            word_cnt       <= '0;
            chn            <= '0;
            o_sample_count <= '0;
        end else begin
            if (last_word) o_sample_count <= o_sample_count + 1'b1;
            if (!busy || last_word) begin
                busy     <= |elig;          // next sample may follow without a gap
                word_cnt <= '0;
                if (|elig) chn <= pick;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== src/ts_store.sv ====
//----------------------------------------------------------
// timestamp store
// per-channel time latches with valid flags, word read-out
//----------------------------------------------------------
`timescale 1ns/1ps

module ts_store import logger_pkg::*; (
    input  logic               i_xclk,
    input  logic               i_config_rst,
    input  logic [NUM_CHN-1:0] i_ts_rq,     // one-cycle requests
    input  logic [TIME_W-1:0]  i_ts_local,  // free-running local time
    input  logic [NUM_CHN-1:0] i_done,      // sample of this channel sent
    input  word_sel_t          i_sel,
    output logic [NUM_CHN-1:0] o_ts_valid,
    output logic [WORD_W-1:0]  o_ts_word
);

    logic [TIME_W-1:0] ts_lat [NUM_CHN];
    logic [TIME_W-1:0] ts_cur;             // latch of the channel being read

    always_ff @(posedge i_xclk) begin
        if (i_config_rst) begin
            o_ts_valid <= '0;
        end else begin
            for (int c = 0; c < NUM_CHN; c++) begin
                if (i_done[c])        o_ts_valid[c] <= 1'b0;
                else if (i_ts_rq[c])  o_ts_valid[c] <= 1'b1;
            end
        end
    end

    // a second request is dropped until the first time is logged
    always_ff @(posedge i_xclk) begin
        for (int c = 0; c < NUM_CHN; c++) begin
            if (i_ts_rq[c] && !o_ts_valid[c]) ts_lat[c] <= i_ts_local;
        end
    end

    assign ts_cur = ts_lat[i_sel.chn];

    always_comb begin
        o_ts_word = '0;
        if (i_sel.ts_en) begin
            case (i_sel.ts_idx)
                2'd0:    o_ts_word = ts_cur[WORD_W-1:0];
                2'd1:    o_ts_word = {i_sel.chn, ts_cur[TIME_W-2 -: WORD_W-CHN_W]};  // chn in msb
                default: o_ts_word = '0;
            endcase
        end
    end

endmodule

// ==== src/msg_channel.sv ====
//----------------------------------------------------------
// odometer message channel
// message word buffer, trigger edges, word read-out
//----------------------------------------------------------
`timescale 1ns/1ps

module msg_channel import logger_pkg::*; (
    input  logic              i_xclk,
    input  logic              i_config_rst,
    input  logger_cfg_t       i_cfg,
    input  msg_wr_t           i_msg_wr,
    input  logic [GPIO_N-1:0] i_ext_di,
    input  logic              i_next,    // advance to next message word
    output logic              o_ts_rq,   // leading edge of trigger
    output logic              o_rdy,     // set by trailing edge
    output logic [WORD_W-1:0] o_data
);

    logic [WORD_W-1:0]             msg_mem [DATA_WORDS];
    logic                          trig_lvl;  // selected and inverted trigger
    logic [2:0]                    sync;      // [1:0] synchronizer, [2] previous level
    logic                          lead;
    logic                          trail;
    logic                          rd_last;
    logic [$clog2(DATA_WORDS)-1:0] rd_idx;
    logic                          en_q;

    assign trig_lvl = gpio_bit(i_ext_di, i_cfg.msg_sel, i_cfg.msg_inv);
    assign lead     = sync[1] && !sync[2];
    assign trail    = !sync[1] && sync[2];
    assign rd_last  = (rd_idx == DATA_WORDS - 1);
    assign o_data   = msg_mem[rd_idx];     // current word, sampled by the output mux

    // software may rewrite words at any time
    always_ff @(posedge i_xclk) begin
        if (i_msg_wr.valid) msg_mem[i_msg_wr.idx] <= i_msg_wr.word;
    end

    always_ff @(posedge i_xclk) begin
        if (i_config_rst) begin
            en_q    <= 1'b0;
            sync    <= '0;
            o_ts_rq <= 1'b0;
            o_rdy   <= 1'b0;
            rd_idx  <= '0;
        end else if (!en_q) begin
            en_q    <= i_cfg.msg_en;
            sync    <= {3{trig_lvl}};      // idle level, no edge on enable
            o_ts_rq <= 1'b0;
            o_rdy   <= 1'b0;
            rd_idx  <= '0;
        end else begin
            en_q    <= i_cfg.msg_en;
            sync    <= {sync[1:0], trig_lvl};
            o_ts_rq <= lead;               // take time on leading edge
            if (trail) begin
                o_rdy <= 1'b1;             // message complete
            end else if (i_next && o_rdy && rd_last) begin
                o_rdy <= 1'b0;             // sixth word read
            end
            if (i_next && o_rdy) begin
                rd_idx <= rd_last ? '0 : rd_idx + 1'b1;  // back to 0 when ready falls
            end
        end
    end

endmodule

// ==== src/pps_filter.sv ====
//----------------------------------------------------------
// gps one-pulse-per-second input channel
// bit select, polarity, synchronizer, denoise, ts request
//----------------------------------------------------------
`timescale 1ns/1ps

module pps_filter import logger_pkg::*; (
    input  logic              i_xclk,
    input  logic              i_config_rst,
    input  logger_cfg_t       i_cfg,
    input  logic [GPIO_N-1:0] i_ext_di,
    input  logic              i_next,    // first data word read by arbiter
    output logic              o_ts_rq,   // one cycle after accepted rising edge
    output logic              o_rdy
);

    logic                              pps_lvl;     // selected and inverted input
    logic [2:0]                        sync;
    logic                              den;         // accepted level
    logic                              den_d;
    logic [$clog2(DENOISE_CYCLES)-1:0] stable_cnt;  // cycles the input differs from den
    logic                              en_q;        // enable, delayed by one cycle

    assign pps_lvl = gpio_bit(i_ext_di, i_cfg.pps_sel, i_cfg.pps_inv);

    always_ff @(posedge i_xclk) begin
        if (i_config_rst) begin
            en_q       <= 1'b0;
            sync       <= '0;
            den        <= 1'b0;
            den_d      <= 1'b0;
            stable_cnt <= '0;
            o_ts_rq    <= 1'b0;
            o_rdy      <= 1'b0;
        end else if (!en_q) begin
            en_q       <= i_cfg.pps_en;
            sync       <= {3{pps_lvl}};  // track the idle level so enabling gives no edge
            den        <= pps_lvl;
            den_d      <= pps_lvl;
            stable_cnt <= '0;
            o_ts_rq    <= 1'b0;
            o_rdy      <= 1'b0;
        end else begin
            en_q <= i_cfg.pps_en;
            sync <= {sync[1:0], pps_lvl};
            if (sync[2] == den) begin
                stable_cnt <= '0;                // noise gone, restart
            end else if (stable_cnt == DENOISE_CYCLES - 1) begin
                den        <= sync[2];           // new level stable long enough
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
            den_d   <= den;
            o_ts_rq <= den && !den_d;            // single pulse per accepted rise
            if (den && !den_d) o_rdy <= 1'b1;
            else if (i_next)   o_rdy <= 1'b0;    // pps carries no data words
        end
    end

endmodule

// ==== src/cmd_regs.sv ====
//----------------------------------------------------------
// command write decoder
// configuration register and registered message word writes
//----------------------------------------------------------
`timescale 1ns/1ps

module cmd_regs import logger_pkg::*; (
    input  logic              i_xclk,
    input  logic              i_config_rst,
    input  logic              i_cmd_we,     // one-cycle write strobe
    input  logic [ADDR_W-1:0] i_cmd_addr,
    input  logic [31:0]       i_cmd_data,
    output logger_cfg_t       o_cfg,
    output msg_wr_t           o_msg_wr      // one cycle after the command
);

    logic              msg_hit;
    logic [ADDR_W-1:0] msg_ofs;

    assign msg_ofs = i_cmd_addr - ADDR_W'(ADDR_MSG_BASE);  // word index inside message page
    assign msg_hit = (i_cmd_addr >= ADDR_W'(ADDR_MSG_BASE)) &&
                     (msg_ofs < ADDR_W'(DATA_WORDS));

    always_ff @(posedge i_xclk) begin
        if (i_config_rst) begin
            o_cfg <= '0;  // both channels off
        end else if (i_cmd_we && (i_cmd_addr == ADDR_W'(ADDR_CONFIG))) begin
            o_cfg <= logger_cfg_t'(i_cmd_data[$bits(logger_cfg_t)-1:0]);
        end
    end

    // message write strobe
    always_ff @(posedge i_xclk) begin
        if (i_config_rst) o_msg_wr.valid <= 1'b0;
        else              o_msg_wr.valid <= i_cmd_we && msg_hit;
    end

    // write payload, qualified by valid
    always_ff @(posedge i_xclk) begin
        o_msg_wr.idx  <= msg_ofs[2:0];
        o_msg_wr.word <= i_cmd_data[WORD_W-1:0];  // upper data bits ignored
    end

endmodule

// ==== src/logger_pkg.sv ====
//----------------------------------------------------------
// event logger shared definitions
// command map, sample layout, config and word-select structs
// gpio bit selection helper
//----------------------------------------------------------
package logger_pkg;

    localparam int GPIO_N         = 10;  // gpio input bits
    localparam int WORD_W         = 16;  // output word
    localparam int TIME_W         = 32;  // local time input
    localparam int NUM_CHN        = 2;   // 0 - pps, 1 - msg
    localparam int CHN_W          = 1;
    localparam int TS_WORDS       = 2;   // timestamp words per sample
    localparam int DATA_WORDS     = 6;   // data words per sample
    localparam int SAMPLE_WORDS   = 8;
    localparam int ADDR_W         = 7;
    localparam int ADDR_CONFIG    = 0;
    localparam int ADDR_MSG_BASE  = 8;   // message words at 8..13
    localparam int DENOISE_CYCLES = 16;  // stable cycles before pps level change is taken
    localparam int SAMPLE_CNT_W   = 16;

    // loaded from cmd data[11:0], pps_sel in the low bits
    typedef struct packed {
        logic       msg_en;   // bit 11
        logic       msg_inv;
        logic [3:0] msg_sel;  // gpio index, >= GPIO_N gives 0
        logic       pps_en;
        logic       pps_inv;
        logic [3:0] pps_sel;  // bits 3:0
    } logger_cfg_t;

    typedef struct packed {
        logic              valid;
        logic [2:0]        idx;   // message word index
        logic [WORD_W-1:0] word;
    } msg_wr_t;

    typedef struct packed {
        logic             valid;   // one word of a sample this cycle
        logic             ts_en;   // timestamp word, else channel data
        logic [CHN_W-1:0] chn;     // channel being served
        logic [1:0]       ts_idx;  // timestamp word index
    } word_sel_t;

    // pick one gpio bit and apply polarity
    function automatic logic gpio_bit(input logic [GPIO_N-1:0] di,
                                      input logic [3:0]        sel,
                                      input logic              inv);
        logic [15:0] di_pad;
        di_pad = 16'(di);  // unused indices read as 0
        return di_pad[sel] ^ inv;
    endfunction

endpackage
